// ==== mips_macros.svh ====
// mips core constants: widths, reset pc, opcode/funct/alu/load/select codes
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define MIPS_WORD_W      32               // data word
`define MIPS_WADDR_W     30               // word address, byte addr bits 31:2
`define MIPS_REG_N       32
`define MIPS_REGA_W      5
`define MIPS_TEXT_START  32'h0040_0000    // reset pc

// primary opcodes
`define MIPS_OP_RTYPE    6'h00
`define MIPS_OP_J        6'h02
`define MIPS_OP_JAL      6'h03
`define MIPS_OP_BEQ      6'h04
`define MIPS_OP_BNE      6'h05
`define MIPS_OP_ADDI     6'h08
`define MIPS_OP_ADDIU    6'h09
`define MIPS_OP_SLTI     6'h0a
`define MIPS_OP_ANDI     6'h0c
`define MIPS_OP_ORI      6'h0d
`define MIPS_OP_XORI     6'h0e
`define MIPS_OP_LUI      6'h0f
`define MIPS_OP_LB       6'h20
`define MIPS_OP_LH       6'h21
`define MIPS_OP_LW       6'h23
`define MIPS_OP_LBU      6'h24
`define MIPS_OP_LHU      6'h25
`define MIPS_OP_SW       6'h2b

// funct field, r-type only
`define MIPS_FN_SLL      6'h00
`define MIPS_FN_SRL      6'h02
`define MIPS_FN_SRA      6'h03
`define MIPS_FN_SLLV     6'h04
`define MIPS_FN_SRLV     6'h06
`define MIPS_FN_SRAV     6'h07
`define MIPS_FN_JR       6'h08
`define MIPS_FN_JALR     6'h09
`define MIPS_FN_SYSCALL  6'h0c
`define MIPS_FN_ADD      6'h20
`define MIPS_FN_ADDU     6'h21
`define MIPS_FN_SUB      6'h22
`define MIPS_FN_SUBU     6'h23
`define MIPS_FN_AND      6'h24
`define MIPS_FN_OR       6'h25
`define MIPS_FN_XOR      6'h26
`define MIPS_FN_NOR      6'h27
`define MIPS_FN_SLT      6'h2a

// alu select
`define MIPS_ALU_ADD     4'h0
`define MIPS_ALU_SUB     4'h1
`define MIPS_ALU_AND     4'h2
`define MIPS_ALU_OR      4'h3
`define MIPS_ALU_XOR     4'h4
`define MIPS_ALU_NOR     4'h5
`define MIPS_ALU_SLT     4'h6
`define MIPS_ALU_SLL     4'h7             // fixed shifts, amount from shamt
`define MIPS_ALU_SRL     4'h8
`define MIPS_ALU_SRA     4'h9
`define MIPS_ALU_SLLV    4'ha             // variable shifts, amount from op_a
`define MIPS_ALU_SRLV    4'hb
`define MIPS_ALU_SRAV    4'hc

// load result format
`define MIPS_LD_LW       3'd0
`define MIPS_LD_LB       3'd1
`define MIPS_LD_LBU      3'd2
`define MIPS_LD_LH       3'd3
`define MIPS_LD_LHU      3'd4
`define MIPS_LD_LUI      3'd5

// next pc choice
`define MIPS_PC_SEQ      2'd0
`define MIPS_PC_BR       2'd1
`define MIPS_PC_JMP      2'd2
`define MIPS_PC_REG      2'd3

// writeback source
`define MIPS_WB_ALU      2'd0
`define MIPS_WB_LOAD     2'd1
`define MIPS_WB_LINK     2'd2

`define MIPS_SYS_EXIT    32'd10           // $v0 value that ends the program
`define MIPS_REG_V0      5'd2
`define MIPS_REG_RA      5'd31

`endif

// ==== mips_pkg.sv ====
// mips core types: width vectors, decoded instruction fields and control word
`include "mips_macros.svh"

package mips_pkg;

   typedef logic [`MIPS_WORD_W-1:0]  word_t;      // data or byte address
   typedef logic [`MIPS_WADDR_W-1:0] waddr_t;     // word address
   typedef logic [`MIPS_REGA_W-1:0]  reg_addr_t;

   typedef logic [3:0] alu_sel_t;    // MIPS_ALU_*
   typedef logic [2:0] ld_sel_t;     // MIPS_LD_*
   typedef logic [1:0] pc_sel_t;     // MIPS_PC_*
   typedef logic [1:0] wb_sel_t;     // MIPS_WB_*

   // raw fields, all formats overlaid
   typedef struct packed {
      logic [5:0]  op;
      logic [5:0]  funct;
      reg_addr_t   rs;
      reg_addr_t   rt;
      reg_addr_t   rd;
      logic [4:0]  shamt;
      logic [15:0] imm;      // also branch offset
      logic [25:0] target;   // j/jal
   } instr_fields_t;

   typedef struct packed {
      logic     reg_we;
      logic     reg_dst_rd;    // else rt
      logic     link;          // write to $ra
      alu_sel_t alu_sel;
      logic     alu_src_imm;   // op_b from extended imm
      logic     imm_sign;      // sign vs zero extend
      logic     shift_var;     // sllv/srlv/srav
      ld_sel_t  ld_sel;
      wb_sel_t  wb_sel;
      logic     mem_we;        // sw
      logic     branch;
      logic     branch_ne;     // bne, else beq
      logic     jump;          // j/jal
      logic     jump_reg;      // jr/jalr
      logic     syscall;
      logic     reserved;      // unknown encoding
   } ctrl_t;

endpackage

// ==== mips_decode.sv ====
// instruction decoder: field split and opcode/funct to control word mapping
`timescale 1ns/10ps
`include "mips_macros.svh"

module mips_decode (
   input  mips_pkg::word_t         inst,
   output mips_pkg::instr_fields_t fields,
   output mips_pkg::ctrl_t         ctrl
);

   // field split, every format at once
   always_comb begin
      fields.op     = inst[31:26];
      fields.rs     = inst[25:21];
      fields.rt     = inst[20:16];
      fields.rd     = inst[15:11];
      fields.shamt  = inst[10:6];
      fields.funct  = inst[5:0];
      fields.imm    = inst[15:0];
      fields.target = inst[25:0];
   end

   always_comb begin
      ctrl         = '0;               // nop unless matched below
      ctrl.alu_sel = `MIPS_ALU_ADD;    // address calc default
      ctrl.ld_sel  = `MIPS_LD_LW;
      ctrl.wb_sel  = `MIPS_WB_ALU;
      case (fields.op)
         `MIPS_OP_RTYPE: begin
            ctrl.reg_we     = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            case (fields.funct)
               `MIPS_FN_ADD, `MIPS_FN_ADDU: ctrl.alu_sel = `MIPS_ALU_ADD;  // no ovf trap
               `MIPS_FN_SUB, `MIPS_FN_SUBU: ctrl.alu_sel = `MIPS_ALU_SUB;
               `MIPS_FN_AND: ctrl.alu_sel = `MIPS_ALU_AND;
               `MIPS_FN_OR:  ctrl.alu_sel = `MIPS_ALU_OR;
               `MIPS_FN_XOR: ctrl.alu_sel = `MIPS_ALU_XOR;
               `MIPS_FN_NOR: ctrl.alu_sel = `MIPS_ALU_NOR;
               `MIPS_FN_SLT: ctrl.alu_sel = `MIPS_ALU_SLT;
               `MIPS_FN_SLL: ctrl.alu_sel = `MIPS_ALU_SLL;
               `MIPS_FN_SRL: ctrl.alu_sel = `MIPS_ALU_SRL;
               `MIPS_FN_SRA: ctrl.alu_sel = `MIPS_ALU_SRA;
               `MIPS_FN_SLLV: begin
                  ctrl.alu_sel   = `MIPS_ALU_SLLV;
                  ctrl.shift_var = 1'b1;
               end
               `MIPS_FN_SRLV: begin
                  ctrl.alu_sel   = `MIPS_ALU_SRLV;
                  ctrl.shift_var = 1'b1;
               end
               `MIPS_FN_SRAV: begin
                  ctrl.alu_sel   = `MIPS_ALU_SRAV;
                  ctrl.shift_var = 1'b1;
               end
               `MIPS_FN_JR: begin
                  ctrl.reg_we   = 1'b0;
                  ctrl.jump_reg = 1'b1;
               end
               `MIPS_FN_JALR: begin
                  ctrl.jump_reg = 1'b1;           // link into rd
                  ctrl.wb_sel   = `MIPS_WB_LINK;
               end
               `MIPS_FN_SYSCALL: begin
                  ctrl.reg_we  = 1'b0;
                  ctrl.syscall = 1'b1;
               end
               default: begin
                  ctrl.reg_we   = 1'b0;
                  ctrl.reserved = 1'b1;
               end
            endcase
         end
         `MIPS_OP_J: ctrl.jump = 1'b1;
         `MIPS_OP_JAL: begin
            ctrl.jump   = 1'b1;
            ctrl.link   = 1'b1;
            ctrl.reg_we = 1'b1;
            ctrl.wb_sel = `MIPS_WB_LINK;
         end
         `MIPS_OP_BEQ: ctrl.branch = 1'b1;
         `MIPS_OP_BNE: begin
            ctrl.branch    = 1'b1;
            ctrl.branch_ne = 1'b1;
         end
         `MIPS_OP_ADDI, `MIPS_OP_ADDIU, `MIPS_OP_SLTI: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_sign    = 1'b1;
            if (fields.op == `MIPS_OP_SLTI)
               ctrl.alu_sel = `MIPS_ALU_SLT;
         end
         `MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;      // zero extended
            case (fields.op)
               `MIPS_OP_ANDI: ctrl.alu_sel = `MIPS_ALU_AND;
               `MIPS_OP_ORI:  ctrl.alu_sel = `MIPS_ALU_OR;
               default:       ctrl.alu_sel = `MIPS_ALU_XOR;
            endcase
         end
         `MIPS_OP_LUI: begin
            ctrl.reg_we = 1'b1;
            ctrl.ld_sel = `MIPS_LD_LUI;   // formatted in the loader
            ctrl.wb_sel = `MIPS_WB_LOAD;
         end
         `MIPS_OP_LB, `MIPS_OP_LBU, `MIPS_OP_LH, `MIPS_OP_LHU, `MIPS_OP_LW: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_sign    = 1'b1;
            ctrl.wb_sel      = `MIPS_WB_LOAD;
            case (fields.op)
               `MIPS_OP_LB:  ctrl.ld_sel = `MIPS_LD_LB;
               `MIPS_OP_LBU: ctrl.ld_sel = `MIPS_LD_LBU;
               `MIPS_OP_LH:  ctrl.ld_sel = `MIPS_LD_LH;
               `MIPS_OP_LHU: ctrl.ld_sel = `MIPS_LD_LHU;
               default:      ctrl.ld_sel = `MIPS_LD_LW;
            endcase
         end
         `MIPS_OP_SW: begin
            ctrl.mem_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_sign    = 1'b1;
         end
         default: ctrl.reserved = 1'b1;   // reg_we/mem_we stay low
      endcase
   end

   // a store never also writes a register, whatever the funct bits
   always_comb begin
      assert final (!(ctrl.mem_we && ctrl.reg_we))
         else $error("decode: store with register write, inst %h", inst);
   end

endmodule

// ==== mips_alu.sv ====
// integer alu: add/sub, logic ops, signed compare and shifts
`timescale 1ns/10ps
`include "mips_macros.svh"

module mips_alu (
   input  mips_pkg::word_t    op_a,
   input  mips_pkg::word_t    op_b,
   input  logic [4:0]         shamt,
   input  mips_pkg::alu_sel_t sel,
   output mips_pkg::word_t    result
);

   logic [4:0] var_amt;     // low rs bits for variable shifts
   logic       lt_signed;

   assign var_amt   = op_a[4:0];
   assign lt_signed = $signed(op_a) < $signed(op_b);

   always_comb begin
      case (sel)
         `MIPS_ALU_ADD:  result = op_a + op_b;
         `MIPS_ALU_SUB:  result = op_a - op_b;
         `MIPS_ALU_AND:  result = op_a & op_b;
         `MIPS_ALU_OR:   result = op_a | op_b;
         `MIPS_ALU_XOR:  result = op_a ^ op_b;
         `MIPS_ALU_NOR:  result = ~(op_a | op_b);
         `MIPS_ALU_SLT:  result = {31'd0, lt_signed};
         // shifted value is always rt on op_b
         `MIPS_ALU_SLL:  result = op_b << shamt;
         `MIPS_ALU_SRL:  result = op_b >> shamt;
         `MIPS_ALU_SRA:  result = mips_pkg::word_t'($signed(op_b) >>> shamt);
         `MIPS_ALU_SLLV: result = op_b << var_amt;
         `MIPS_ALU_SRLV: result = op_b >> var_amt;
         `MIPS_ALU_SRAV: result = mips_pkg::word_t'($signed(op_b) >>> var_amt);
         default:        result = '0;   // unused codes
      endcase
   end

endmodule

// ==== mips_regfile.sv ====
// register file: 32 x 32, two async read ports, one write port, $zero fixed
`timescale 1ns/10ps
`include "mips_macros.svh"

module mips_regfile (
   input  logic                 clk,
   input  logic                 rst_b,
   input  mips_pkg::reg_addr_t  rs,
   input  mips_pkg::reg_addr_t  rt,
   input  mips_pkg::reg_addr_t  wr_addr,
   input  mips_pkg::word_t      wr_data,
   input  logic                 we,
   output mips_pkg::word_t      rs_data,
   output mips_pkg::word_t      rt_data
);

   mips_pkg::word_t regs [`MIPS_REG_N];

   // architectural state starts cleared
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < `MIPS_REG_N; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (wr_addr != '0)) begin   // writes to $zero dropped
         regs[wr_addr] <= wr_data;
      end
   end

   assign rs_data = regs[rs];   // combinational read
   assign rt_data = regs[rt];

   a_zero_reads_zero: assert property (
      @(posedge clk) disable iff (!rst_b)
      ((rs == '0) |-> (rs_data == '0)) and ((rt == '0) |-> (rt_data == '0))
   ) else $error("regfile: $zero read nonzero");

endmodule

// ==== mips_fetch.sv ====
// fetch: pc register and next-pc select for step, branch, jump and jump-register
`timescale 1ns/10ps
`include "mips_macros.svh"

module mips_fetch (
   input  logic                    clk,
   input  logic                    rst_b,
   input  logic                    hold,       // halted, pc frozen
   input  mips_pkg::instr_fields_t fields,
   input  mips_pkg::ctrl_t         ctrl,
   input  mips_pkg::word_t         rs_data,
   input  mips_pkg::word_t         rt_data,
   output mips_pkg::word_t         pc,
   output mips_pkg::word_t         pc_plus4
);

   mips_pkg::pc_sel_t pc_sel;
   mips_pkg::word_t   br_off;
   mips_pkg::word_t   next_pc;
   logic              taken;

   assign pc_plus4 = pc + 32'd4;
   assign br_off   = {{14{fields.imm[15]}}, fields.imm, 2'b00};   // word offset
   assign taken    = ctrl.branch && ((rs_data == rt_data) != ctrl.branch_ne);

   always_comb begin
      if (ctrl.jump_reg)
         pc_sel = `MIPS_PC_REG;
      else if (ctrl.jump)
         pc_sel = `MIPS_PC_JMP;
      else if (taken)
         pc_sel = `MIPS_PC_BR;
      else
         pc_sel = `MIPS_PC_SEQ;
   end

   // no delay slot, redirect hits the very next fetch
   always_comb begin
      case (pc_sel)
         `MIPS_PC_BR:  next_pc = pc_plus4 + br_off;
         `MIPS_PC_JMP: next_pc = {pc[31:28], fields.target, 2'b00};   // same 256MB region
         `MIPS_PC_REG: next_pc = rs_data;
         default:      next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b)
         pc <= `MIPS_TEXT_START;
      else if (!hold)
         pc <= next_pc;
   end

   a_pc_aligned: assert property (
      @(posedge clk) disable iff (!rst_b) pc[1:0] == 2'b00
   ) else $error("fetch: pc %h not word aligned", pc);

endmodule

// ==== mips_loader.sv ====
// load formatter: lui placement and byte/half/word extension of read data
`timescale 1ns/10ps
`include "mips_macros.svh"

module mips_loader (
   input  logic [15:0]       imm,
   input  mips_pkg::word_t   mem_data,
   input  mips_pkg::ld_sel_t sel,
   output mips_pkg::word_t   load_data
);

   // sub-word loads take the low lanes, no byte steering by address
   always_comb begin
      case (sel)
         `MIPS_LD_LUI: load_data = {imm, 16'h0000};
         `MIPS_LD_LB:  load_data = {{24{mem_data[7]}}, mem_data[7:0]};
         `MIPS_LD_LBU: load_data = {24'd0, mem_data[7:0]};
         `MIPS_LD_LH:  load_data = {{16{mem_data[15]}}, mem_data[15:0]};
         `MIPS_LD_LHU: load_data = {16'd0, mem_data[15:0]};
         default:      load_data = mem_data;   // lw
      endcase
   end

endmodule

// ==== mips_core.sv ====
// single-cycle mips core top: halt logic, operand and writeback muxes, datapath
`timescale 1ns/10ps
`include "mips_macros.svh"

module mips_core (
   input  logic             clk,
   input  logic             rst_b,
   input  mips_pkg::word_t  inst,
   input  mips_pkg::word_t  mem_data_out,
   output mips_pkg::waddr_t inst_addr,
   output mips_pkg::waddr_t mem_addr,
   output mips_pkg::word_t  mem_data_in,
   output logic [3:0]       mem_write_en,
   output logic             halted
);

   mips_pkg::instr_fields_t fields;
   mips_pkg::ctrl_t         ctrl;
   mips_pkg::word_t         pc, pc_plus4;
   mips_pkg::word_t         rs_data, rt_data;
   mips_pkg::word_t         ext_imm, alu_b, alu_out;
   mips_pkg::word_t         load_data, wr_data;
   mips_pkg::reg_addr_t     rs_addr, wr_addr;
   logic                    halt_next;

   mips_decode i_decode (.inst(inst), .fields(fields), .ctrl(ctrl));

   // syscall has rs=0, so borrow port a to read $v0
   assign rs_addr = ctrl.syscall ? `MIPS_REG_V0 : fields.rs;

   mips_regfile i_regfile (
      .clk(clk), .rst_b(rst_b),
      .rs(rs_addr), .rt(fields.rt),
      .wr_addr(wr_addr), .wr_data(wr_data),
      .we(ctrl.reg_we && !halted),   // no writes once stopped
      .rs_data(rs_data), .rt_data(rt_data)
   );

   assign ext_imm = ctrl.imm_sign ? {{16{fields.imm[15]}}, fields.imm} : {16'd0, fields.imm};
   // variable shifts: rs amount on op_a, rt value on op_b, imm never used
   assign alu_b   = (ctrl.alu_src_imm && !ctrl.shift_var) ? ext_imm : rt_data;

   mips_alu i_alu (
      .op_a(rs_data), .op_b(alu_b), .shamt(fields.shamt),
      .sel(ctrl.alu_sel), .result(alu_out)
   );

   mips_loader i_loader (
      .imm(fields.imm), .mem_data(mem_data_out), .sel(ctrl.ld_sel), .load_data(load_data)
   );

   mips_fetch i_fetch (
      .clk(clk), .rst_b(rst_b), .hold(halted),
      .fields(fields), .ctrl(ctrl),
      .rs_data(rs_data), .rt_data(rt_data),
      .pc(pc), .pc_plus4(pc_plus4)
   );

   always_comb begin
      if (ctrl.link)
         wr_addr = `MIPS_REG_RA;          // jal
      else if (ctrl.reg_dst_rd)
         wr_addr = fields.rd;             // r-type, jalr
      else
         wr_addr = fields.rt;
   end

   always_comb begin
      case (ctrl.wb_sel)
         `MIPS_WB_LOAD: wr_data = load_data;
         `MIPS_WB_LINK: wr_data = pc_plus4;   // no delay slot, so pc+4
         default:       wr_data = alu_out;
      endcase
   end

   assign inst_addr    = pc[31:2];
   assign mem_addr     = alu_out[31:2];
   assign mem_data_in  = rt_data;
   assign mem_write_en = (ctrl.mem_we && !halted) ? 4'b1111 : 4'b0000;   // sw only

   // exit syscall or reserved encoding stops the core
   assign halt_next = (ctrl.syscall && (rs_data == `MIPS_SYS_EXIT)) || ctrl.reserved;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b)
         halted <= 1'b0;
      else if (halt_next)
         halted <= 1'b1;                  // sticky until reset
   end

   a_halt_sticky: assert property (
      @(posedge clk) disable iff (!rst_b) halted |=> halted
   ) else $error("core: halted dropped without reset");

endmodule

// ==== mips_tb.sv ====
// mips core testbench: table of instructions and expected port values, run in a loop
`timescale 1ns/10ps
`include "mips_macros.svh"

module mips_tb;

   typedef struct packed {
      logic [7:0]  test_no;
      logic [31:0] inst;
      logic [31:0] mdo;         // read data returned for this row
      logic [29:0] exp_iaddr;
      logic [3:0]  exp_we;
      logic [29:0] exp_maddr;   // only checked on stores
      logic [31:0] exp_mdata;
      logic        exp_halt;
   } row_t;

   logic              clk;
   logic              rst_b;
   mips_pkg::word_t   inst;
   mips_pkg::word_t   mem_data_out;
   mips_pkg::waddr_t  inst_addr;
   mips_pkg::waddr_t  mem_addr;
   mips_pkg::word_t   mem_data_in;
   logic [3:0]        mem_write_en;
   logic              halted;

   row_t        rows[$];
   int          seed = 19251;
   logic [31:0] bpc;                 // pc the table expects next
   logic [31:0] rnd;                 // read data of the last row built
   logic        bhalt;               // core expected halted
   logic [7:0]  cur_test;
   int          second_reset_at = -1;
   int          cycles = 0;
   int          cycle_limit = 100;   // replaced once the table is built
   int          n_checks = 0;
   int          err_count = 0;
   int          test_errs = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   mips_core i_dut (
      .clk(clk), .rst_b(rst_b),
      .inst(inst), .mem_data_out(mem_data_out),
      .inst_addr(inst_addr), .mem_addr(mem_addr),
      .mem_data_in(mem_data_in), .mem_write_en(mem_write_en),
      .halted(halted)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   // instruction encoders
   function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] sh,
                                         input logic [5:0] fn);
      return {`MIPS_OP_RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] jtype(input logic [5:0] op, input logic [25:0] tgt);
      return {op, tgt};
   endfunction

   task automatic push_row(input logic [31:0] instr, input logic [31:0] nxt,
                           input logic is_st, input logic [31:0] st_val);
      row_t r;
      rnd         = $random(seed);
      r.test_no   = cur_test;
      r.inst      = instr;
      r.mdo       = rnd;
      r.exp_iaddr = bpc[31:2];
      r.exp_we    = (is_st && !bhalt) ? 4'b1111 : 4'b0000;
      r.exp_maddr = 30'h40;          // sw always targets 0x100($zero)
      r.exp_mdata = st_val;
      r.exp_halt  = bhalt;
      rows.push_back(r);
      if (!bhalt)
         bpc = nxt;                  // frozen once halted
   endtask

   task automatic step(input logic [31:0] instr);
      push_row(instr, bpc + 32'd4, 1'b0, 32'd0);
   endtask

   // sw rt, 0x100($zero) exposes a register on mem_data_in
   task automatic store(input logic [4:0] rt, input logic [31:0] val);
      push_row(itype(`MIPS_OP_SW, 5'd0, rt, 16'h0100), bpc + 32'd4, 1'b1, val);
   endtask

   task automatic exec_and_store(input logic [31:0] instr, input logic [4:0] rd,
                                 input logic [31:0] val);
      step(instr);
      store(rd, val);
   endtask

   task automatic build_table();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] lnk;
      a     = 32'h0000_7fff;
      b     = 32'hffff_8000;
      bpc   = `MIPS_TEXT_START;
      bhalt = 1'b0;
      cur_test = 8'd1;               // reset pc and plain stepping
      step(32'h0000_0000);
      step(32'h0000_0000);
      cur_test = 8'd2;               // alu and immediate ops
      exec_and_store(itype(`MIPS_OP_ADDIU, 5'd0, 5'd8, 16'h7fff), 5'd8, a);
      exec_and_store(itype(`MIPS_OP_ADDI, 5'd0, 5'd9, 16'h8000), 5'd9, b);   // sign ext
      exec_and_store(rtype(5'd8, 5'd9, 5'd10, 5'd0, `MIPS_FN_ADD), 5'd10, a + b);
      exec_and_store(rtype(5'd8, 5'd8, 5'd11, 5'd0, `MIPS_FN_ADDU), 5'd11, a + a);
      exec_and_store(rtype(5'd9, 5'd8, 5'd12, 5'd0, `MIPS_FN_SUB), 5'd12, b - a);
      exec_and_store(rtype(5'd8, 5'd9, 5'd13, 5'd0, `MIPS_FN_SUBU), 5'd13, a - b);
      exec_and_store(rtype(5'd8, 5'd9, 5'd14, 5'd0, `MIPS_FN_AND), 5'd14, a & b);
      exec_and_store(rtype(5'd8, 5'd9, 5'd15, 5'd0, `MIPS_FN_OR), 5'd15, a | b);
      exec_and_store(rtype(5'd8, 5'd9, 5'd16, 5'd0, `MIPS_FN_XOR), 5'd16, a ^ b);
      exec_and_store(rtype(5'd8, 5'd9, 5'd17, 5'd0, `MIPS_FN_NOR), 5'd17, ~(a | b));
      exec_and_store(rtype(5'd9, 5'd8, 5'd18, 5'd0, `MIPS_FN_SLT), 5'd18, 32'd1);
      exec_and_store(rtype(5'd8, 5'd9, 5'd19, 5'd0, `MIPS_FN_SLT), 5'd19, 32'd0);
      exec_and_store(rtype(5'd0, 5'd8, 5'd20, 5'd4, `MIPS_FN_SLL), 5'd20, a << 4);
      exec_and_store(rtype(5'd0, 5'd9, 5'd21, 5'd8, `MIPS_FN_SRL), 5'd21, b >> 8);
      exec_and_store(rtype(5'd0, 5'd9, 5'd22, 5'd8, `MIPS_FN_SRA), 5'd22, 32'hffff_ff80);
      exec_and_store(itype(`MIPS_OP_ADDIU, 5'd0, 5'd23, 16'd3), 5'd23, 32'd3);
      exec_and_store(rtype(5'd23, 5'd8, 5'd24, 5'd0, `MIPS_FN_SLLV), 5'd24, a << 3);
      exec_and_store(rtype(5'd23, 5'd9, 5'd25, 5'd0, `MIPS_FN_SRLV), 5'd25, b >> 3);
      exec_and_store(rtype(5'd23, 5'd9, 5'd26, 5'd0, `MIPS_FN_SRAV), 5'd26, 32'hffff_f000);
      exec_and_store(itype(`MIPS_OP_SLTI, 5'd9, 5'd27, 16'd1), 5'd27, 32'd1);
      exec_and_store(itype(`MIPS_OP_SLTI, 5'd8, 5'd27, 16'hffff), 5'd27, 32'd0);   // vs -1
      exec_and_store(itype(`MIPS_OP_ANDI, 5'd9, 5'd28, 16'hf0f0), 5'd28, b & 32'h0000_f0f0);
      exec_and_store(itype(`MIPS_OP_ORI, 5'd9, 5'd29, 16'h00ff), 5'd29, b | 32'h0000_00ff);
      exec_and_store(itype(`MIPS_OP_XORI, 5'd8, 5'd30, 16'hffff), 5'd30, a ^ 32'h0000_ffff);
      exec_and_store(itype(`MIPS_OP_ADDIU, 5'd0, 5'd0, 16'h0005), 5'd0, 32'd0);   // $zero
      cur_test = 8'd3;               // loads and lui on random read data
      step(itype(`MIPS_OP_LW, 5'd0, 5'd3, 16'h0200));
      store(5'd3, rnd);
      step(itype(`MIPS_OP_LB, 5'd0, 5'd3, 16'h0200));
      store(5'd3, {{24{rnd[7]}}, rnd[7:0]});
      step(itype(`MIPS_OP_LBU, 5'd0, 5'd3, 16'h0200));
      store(5'd3, {24'd0, rnd[7:0]});
      step(itype(`MIPS_OP_LH, 5'd0, 5'd3, 16'h0200));
      store(5'd3, {{16{rnd[15]}}, rnd[15:0]});
      step(itype(`MIPS_OP_LHU, 5'd0, 5'd3, 16'h0200));
      store(5'd3, {16'd0, rnd[15:0]});
      exec_and_store(itype(`MIPS_OP_LUI, 5'd0, 5'd7, 16'habcd), 5'd7, 32'habcd_0000);
      cur_test = 8'd4;               // branches and jumps, no delay slot
      push_row(itype(`MIPS_OP_BEQ, 5'd8, 5'd8, 16'd2), bpc + 32'd12, 1'b0, 32'd0);
      step(itype(`MIPS_OP_BNE, 5'd8, 5'd8, 16'd2));                 // not taken
      push_row(itype(`MIPS_OP_BNE, 5'd8, 5'd9, 16'd3), bpc + 32'd16, 1'b0, 32'd0);
      step(itype(`MIPS_OP_BEQ, 5'd8, 5'd9, 16'd5));                 // not taken
      push_row(itype(`MIPS_OP_BNE, 5'd8, 5'd9, 16'hfffe), bpc - 32'd4, 1'b0, 32'd0);
      push_row(jtype(`MIPS_OP_J, 26'h010_0100), {bpc[31:28], 26'h010_0100, 2'b00},
               1'b0, 32'd0);
      lnk = bpc + 32'd4;
      push_row(jtype(`MIPS_OP_JAL, 26'h010_0200), {bpc[31:28], 26'h010_0200, 2'b00},
               1'b0, 32'd0);
      store(5'd31, lnk);
      push_row(rtype(5'd31, 5'd0, 5'd0, 5'd0, `MIPS_FN_JR), lnk, 1'b0, 32'd0);
      step(itype(`MIPS_OP_LUI, 5'd0, 5'd4, 16'h0040));
      step(itype(`MIPS_OP_ORI, 5'd4, 5'd4, 16'h0c00));
      lnk = bpc + 32'd4;
      push_row(rtype(5'd4, 5'd0, 5'd5, 5'd0, `MIPS_FN_JALR), 32'h0040_0c00, 1'b0, 32'd0);
      store(5'd5, lnk);
      cur_test = 8'd5;               // exit syscall
      step(rtype(5'd0, 5'd0, 5'd0, 5'd0, `MIPS_FN_SYSCALL));       // $v0 is 0, runs on
      step(itype(`MIPS_OP_ADDIU, 5'd0, 5'd2, 16'd10));
      step(rtype(5'd0, 5'd0, 5'd0, 5'd0, `MIPS_FN_SYSCALL));
      bhalt = 1'b1;
      store(5'd8, a);
      step(itype(`MIPS_OP_ADDIU, 5'd0, 5'd8, 16'd1));
      store(5'd8, a);
      cur_test = 8'd6;               // reserved opcode after a fresh reset
      second_reset_at = rows.size();
      bpc   = `MIPS_TEXT_START;
      bhalt = 1'b0;
      store(5'd8, 32'd0);            // registers cleared by reset
      step(itype(6'h3f, 5'd0, 5'd0, 16'd0));
      bhalt = 1'b1;
      step(itype(`MIPS_OP_ADDIU, 5'd0, 5'd8, 16'd1));
      store(5'd8, 32'd0);
   endtask

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         $display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
         err_count++;
         test_errs++;
      end
   endtask

   task automatic close_test(input logic [7:0] tn);
      tests_run++;
      if (test_errs != 0) begin
         tests_failed++;
         $display("test %0d: failed, %0d errors", tn, test_errs);
      end else begin
         $display("test %0d: ok", tn);
      end
      test_errs = 0;
   endtask

   initial begin
      row_t row;
      rst_b        = 1'b0;
      inst         = '0;
      mem_data_out = '0;
      build_table();
      cycle_limit = rows.size() + 8 + 20;
      repeat (8) @(posedge clk);
      #1 rst_b = 1'b1;
      for (int i = 0; i < rows.size(); i++) begin
         row = rows[i];
         if (i == second_reset_at) begin
            rst_b = 1'b0;            // async clear, halted drops
            repeat (2) @(posedge clk);
            #1 rst_b = 1'b1;
         end
         inst         = row.inst;
         mem_data_out = row.mdo;
         #2;                         // just before the next edge
         compare("inst_addr", inst_addr, row.exp_iaddr);
         compare("mem_write_en", mem_write_en, row.exp_we);
         if (row.exp_we != 4'b0000) begin
            compare("mem_addr", mem_addr, row.exp_maddr);
            compare("mem_data_in", mem_data_in, row.exp_mdata);
         end
         compare("halted", halted, row.exp_halt);
         if (i == rows.size() - 1 || rows[i + 1].test_no != row.test_no)
            close_test(row.test_no);
         @(posedge clk);
         #1;
      end
      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, n_checks, err_count);
      if (err_count == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   // run length guard
   initial begin
      while (cycles <= cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not end within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+.
mips_pkg.sv
mips_decode.sv
mips_alu.sv
mips_regfile.sv
mips_fetch.sv
mips_loader.sv
mips_core.sv
mips_tb.sv

// ==== Bender.yml ====
package:
  name: mips_core

export_include_dirs:
  - .

sources:
  - mips_pkg.sv
  - mips_decode.sv
  - mips_alu.sv
  - mips_regfile.sv
  - mips_fetch.sv
  - mips_loader.sv
  - mips_core.sv
  - target: test
    files:
      - mips_tb.sv
